// File: common/video_pkg.sv
// video pixel definitions
package video_pkg;

    localparam int BYTE_W = 8;  // one camera byte
    localparam int PIX_W  = 16; // packed rgb565 word
    localparam int CH_W   = 8;  // rgb888 output channel

    localparam int R_W = 5; // 565 red field
    localparam int G_W = 6; // 565 green field
    localparam int B_W = 5; // 565 blue field

    // rgb565 pixel, red in the top bits
    typedef struct packed {
        logic [R_W-1:0] r;
        logic [G_W-1:0] g;
        logic [B_W-1:0] b;
    } pixel_t;

    localparam int FIFO_DEPTH = 16; // entries per fusion fifo
    localparam int FIFO_AW    = 4;  // log2 of depth

endpackage

// File: common/ctrl_pkg.sv
// control register definitions
package ctrl_pkg;

    localparam int ADDR_W = 4;  // axi4-lite address bits
    localparam int DATA_W = 32; // axi4-lite data bits

    localparam logic [ADDR_W-1:0] REG_MODE   = 4'h0; // output source select
    localparam logic [ADDR_W-1:0] REG_STATUS = 4'h4; // frame count and overflow

    // output source, value 3 is illegal
    typedef enum logic [1:0] {
        MODE_CAM1 = 2'd0,
        MODE_CAM2 = 2'd1,
        MODE_FUSE = 2'd2
    } mode_t;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam int STAT_OVF_BIT   = 0; // sticky fusion overflow
    localparam int STAT_FRAME_LSB = 8; // 8-bit frame count starts here

endpackage

// File: capture/byte_packer.sv
// camera byte pair packer
module byte_packer import video_pkg::*; (
    input  logic              core_clk,
    input  logic              rst_i,
    input  logic [BYTE_W-1:0] data_i,
    input  logic              href_i,
    input  logic              vsync_i,
    output pixel_t            pix_o,
    output logic              pix_valid_o,
    output logic              vsync_o
);

    logic [BYTE_W-1:0] data_q; // input stage
    logic              href_q;
    logic              vsync_q;
    logic              phase_q; // 0 waits for high byte
    logic [BYTE_W-1:0] hi_q;    // held high byte
    logic [PIX_W-1:0]  raw_w;

    assign raw_w = {hi_q, data_q}; // high byte came first

    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            href_q      <= 1'b0;
            vsync_q     <= 1'b0;
            vsync_o     <= 1'b0;
            phase_q     <= 1'b0;
            pix_valid_o <= 1'b0;
        end else begin
            href_q  <= href_i;
            vsync_q <= vsync_i;
            vsync_o <= vsync_q; // 2 cycles behind the port, like the pixels
            if (!href_q || vsync_q) begin
                phase_q <= 1'b0; // resync to the high byte
            end else begin
                phase_q <= ~phase_q;
            end
            pix_valid_o <= href_q && !vsync_q && phase_q; // low byte in stage
        end
    end

    always_ff @(posedge core_clk) begin
        data_q <= data_i;
        if (href_q && !phase_q) begin
            hi_q <= data_q;
        end
        if (href_q && phase_q) begin
            // red and blue swap places
            pix_o.r <= raw_w[R_W-1:0];
            pix_o.g <= raw_w[R_W +: G_W];
            pix_o.b <= raw_w[PIX_W-1 -: B_W];
        end
    end

endmodule

// File: fusion/pixel_fifo.sv
// pixel fifo with flush
module pixel_fifo import video_pkg::*; (
    input  logic   core_clk,
    input  logic   rst_i,
    input  logic   flush_i,
    input  logic   push_i,
    input  pixel_t push_data_i,
    input  logic   pop_i,
    output pixel_t pop_data_o,
    output logic   empty_o,
    output logic   full_o,
    output logic   ovf_o
);

    pixel_t             mem_q [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr_q;
    logic [FIFO_AW-1:0] rd_ptr_q;
    logic [FIFO_AW:0]   count_q; // one extra bit for full
    logic               do_push;
    logic               do_pop;

    assign empty_o    = (count_q == '0);
    assign full_o     = (count_q == (FIFO_AW+1)'(FIFO_DEPTH));
    assign do_push    = push_i && !full_o && !flush_i;
    assign do_pop     = pop_i && !empty_o && !flush_i;
    assign pop_data_o = mem_q[rd_ptr_q]; // head is always visible

    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge core_clk) begin
        if (rst_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            ovf_o    <= 1'b0;
        end else begin
            ovf_o <= push_i && full_o; // dropped pixel
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // none or both
            endcase
        end
    end

endmodule

// File: fusion/pixel_fuse.sv
// two-camera pixel averaging
module pixel_fuse import video_pkg::*; (
    input  logic   core_clk,
    input  logic   rst_i,
    input  logic   frame_i,
    input  pixel_t cam1_pix_i,
    input  logic   cam1_valid_i,
    input  pixel_t cam2_pix_i,
    input  logic   cam2_valid_i,
    output pixel_t fuse_pix_o,
    output logic   fuse_valid_o,
    output logic   ovf_o
);

    logic         frame_q;
    logic         flush_w; // frame start
    logic         pop_w;
    pixel_t       head1_w;
    pixel_t       head2_w;
    logic         empty1_w, empty2_w;
    logic         ovf1_w, ovf2_w;
    logic [R_W:0] r_sum_w; // one carry bit each
    logic [G_W:0] g_sum_w;
    logic [B_W:0] b_sum_w;

    assign flush_w = frame_i && !frame_q;
    assign pop_w   = !empty1_w && !empty2_w; // a pair is ready
    assign ovf_o   = ovf1_w || ovf2_w;

    pixel_fifo u_fifo1 (
        .core_clk    (core_clk),
        .rst_i       (rst_i),
        .flush_i     (flush_w),
        .push_i      (cam1_valid_i),
        .push_data_i (cam1_pix_i),
        .pop_i       (pop_w),
        .pop_data_o  (head1_w),
        .empty_o     (empty1_w),
        .full_o      (),
        .ovf_o       (ovf1_w)
    );

    pixel_fifo u_fifo2 (
        .core_clk    (core_clk),
        .rst_i       (rst_i),
        .flush_i     (flush_w),
        .push_i      (cam2_valid_i),
        .push_data_i (cam2_pix_i),
        .pop_i       (pop_w), // pops with fifo 1
        .pop_data_o  (head2_w),
        .empty_o     (empty2_w),
        .full_o      (),
        .ovf_o       (ovf2_w)
    );

    assign r_sum_w = head1_w.r + head2_w.r;
    assign g_sum_w = head1_w.g + head2_w.g;
    assign b_sum_w = head1_w.b + head2_w.b;

    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            frame_q      <= 1'b0;
            fuse_valid_o <= 1'b0;
        end else begin
            frame_q      <= frame_i;
            fuse_valid_o <= pop_w && !flush_w;
        end
    end

    always_ff @(posedge core_clk) begin
        fuse_pix_o.r <= r_sum_w[R_W:1]; // floor average
        fuse_pix_o.g <= g_sum_w[G_W:1];
        fuse_pix_o.b <= b_sum_w[B_W:1];
    end

endmodule

// File: logic/ctrl_regs.sv
// axi4-lite control registers
module ctrl_regs import ctrl_pkg::*; (
    input  logic              core_clk,
    input  logic              rst_i,
    input  logic [ADDR_W-1:0] s_awaddr_i,
    input  logic              s_awvalid_i,
    output logic              s_awready_o,
    input  logic [DATA_W-1:0] s_wdata_i,
    input  logic              s_wvalid_i,
    output logic              s_wready_o,
    output logic [1:0]        s_bresp_o,
    output logic              s_bvalid_o,
    input  logic              s_bready_i,
    input  logic [ADDR_W-1:0] s_araddr_i,
    input  logic              s_arvalid_i,
    output logic              s_arready_o,
    output logic [DATA_W-1:0] s_rdata_o,
    output logic [1:0]        s_rresp_o,
    output logic              s_rvalid_o,
    input  logic              s_rready_i,
    input  logic              frame_start_i,
    input  logic              ovf_i,
    output mode_t             mode_o
);

    logic              wr_acc_w; // write address and data taken
    logic              rd_acc_w;
    logic              wr_raise_w;
    logic              mode_ok_w;
    logic              clr_ovf_w;
    logic [7:0]        frame_cnt_q;
    logic              ovf_q; // sticky
    logic [DATA_W-1:0] status_w;

    assign wr_acc_w   = s_awready_o && s_awvalid_i && s_wvalid_i;
    assign rd_acc_w   = s_arready_o && s_arvalid_i;
    assign wr_raise_w = s_awvalid_i && s_wvalid_i && !s_bvalid_o && !s_awready_o;
    assign mode_ok_w  = (s_wdata_i <= DATA_W'(MODE_FUSE)); // 3 and up rejected
    assign clr_ovf_w  = wr_acc_w && (s_awaddr_i == REG_STATUS);

    always_comb begin
        status_w                       = '0;
        status_w[STAT_OVF_BIT]         = ovf_q;
        status_w[STAT_FRAME_LSB +: 8]  = frame_cnt_q;
    end

    // write channel
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            s_awready_o <= 1'b0;
            s_wready_o  <= 1'b0;
            s_bvalid_o  <= 1'b0;
            s_bresp_o   <= RESP_OKAY;
            mode_o      <= MODE_CAM1;
        end else if (wr_acc_w) begin
            s_awready_o <= 1'b0; // single-cycle ready
            s_wready_o  <= 1'b0;
            s_bvalid_o  <= 1'b1;
            if (s_awaddr_i == REG_MODE && mode_ok_w) begin
                mode_o    <= mode_t'(s_wdata_i[1:0]);
                s_bresp_o <= RESP_OKAY;
            end else if (s_awaddr_i == REG_STATUS) begin
                s_bresp_o <= RESP_OKAY; // clears overflow below
            end else begin
                s_bresp_o <= RESP_SLVERR; // bad mode or unmapped
            end
        end else begin
            s_awready_o <= wr_raise_w;
            s_wready_o  <= wr_raise_w;
            if (s_bvalid_o && s_bready_i) begin
                s_bvalid_o <= 1'b0;
            end
        end
    end

    // read channel
    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            s_arready_o <= 1'b0;
            s_rvalid_o  <= 1'b0;
        end else if (rd_acc_w) begin
            s_arready_o <= 1'b0;
            s_rvalid_o  <= 1'b1;
        end else if (s_rvalid_o && s_rready_i) begin
            s_rvalid_o  <= 1'b0;
            s_arready_o <= 1'b1;
        end else if (!s_rvalid_o) begin
            s_arready_o <= 1'b1;
        end
    end

    always_ff @(posedge core_clk) begin
        if (rd_acc_w) begin
            case (s_araddr_i)
                REG_MODE: begin
                    s_rdata_o <= DATA_W'(mode_o);
                    s_rresp_o <= RESP_OKAY;
                end
                REG_STATUS: begin
                    s_rdata_o <= status_w;
                    s_rresp_o <= RESP_OKAY;
                end
                default: begin
                    s_rdata_o <= '0;
                    s_rresp_o <= RESP_SLVERR;
                end
            endcase
        end
    end

    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            frame_cnt_q <= '0;
            ovf_q       <= 1'b0;
        end else begin
            if (frame_start_i) begin
                frame_cnt_q <= frame_cnt_q + 1'b1; // wraps at 256
            end
            if (ovf_i) begin
                ovf_q <= 1'b1; // a new overflow wins over clear
            end else if (clr_ovf_w) begin
                ovf_q <= 1'b0;
            end
        end
    end

endmodule

// File: logic/stream_select.sv
// output stream selector
module stream_select import video_pkg::*, ctrl_pkg::*; (
    input  logic            core_clk,
    input  logic            rst_i,
    input  mode_t           mode_i,
    input  pixel_t          cam1_pix_i,
    input  logic            cam1_valid_i,
    input  logic            cam1_vs_i,
    input  pixel_t          cam2_pix_i,
    input  logic            cam2_valid_i,
    input  logic            cam2_vs_i,
    input  pixel_t          fuse_pix_i,
    input  logic            fuse_valid_i,
    output logic [CH_W-1:0] out_r_o,
    output logic [CH_W-1:0] out_g_o,
    output logic [CH_W-1:0] out_b_o,
    output logic            out_de_o,
    output logic            out_vs_o,
    output logic            frame_start_o
);

    mode_t  mode_q; // held for the whole frame
    logic   vs1_q;
    pixel_t sel_pix_w;
    logic   sel_valid_w;
    logic   sel_vs_w;

    assign frame_start_o = cam1_vs_i && !vs1_q; // cam1 vsync rise

    always_comb begin
        case (mode_q)
            MODE_CAM2: begin
                sel_pix_w   = cam2_pix_i;
                sel_valid_w = cam2_valid_i;
                sel_vs_w    = cam2_vs_i;
            end
            MODE_FUSE: begin
                sel_pix_w   = fuse_pix_i;
                sel_valid_w = fuse_valid_i;
                sel_vs_w    = cam1_vs_i; // fusion frames follow cam1
            end
            default: begin
                sel_pix_w   = cam1_pix_i;
                sel_valid_w = cam1_valid_i;
                sel_vs_w    = cam1_vs_i;
            end
        endcase
    end

    always_ff @(posedge core_clk) begin
        if (rst_i) begin
            mode_q   <= MODE_CAM1;
            vs1_q    <= 1'b0;
            out_de_o <= 1'b0;
            out_vs_o <= 1'b0;
        end else begin
            vs1_q    <= cam1_vs_i;
            out_de_o <= sel_valid_w;
            out_vs_o <= sel_vs_w;
            if (frame_start_o) begin
                mode_q <= mode_i;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        out_r_o <= {sel_pix_w.r, {(CH_W-R_W){1'b0}}}; // zero low bits
        out_g_o <= {sel_pix_w.g, {(CH_W-G_W){1'b0}}};
        out_b_o <= {sel_pix_w.b, {(CH_W-B_W){1'b0}}};
    end

endmodule

// File: logic/video_mux_top.sv
// dual camera video mux top
module video_mux_top import video_pkg::*, ctrl_pkg::*; (
    input  logic              core_clk,
    input  logic              rst_i,
    input  logic [BYTE_W-1:0] cam1_data_i,
    input  logic              cam1_href_i,
    input  logic              cam1_vsync_i,
    input  logic [BYTE_W-1:0] cam2_data_i,
    input  logic              cam2_href_i,
    input  logic              cam2_vsync_i,
    input  logic [ADDR_W-1:0] s_awaddr_i,
    input  logic              s_awvalid_i,
    output logic              s_awready_o,
    input  logic [DATA_W-1:0] s_wdata_i,
    input  logic              s_wvalid_i,
    output logic              s_wready_o,
    output logic [1:0]        s_bresp_o,
    output logic              s_bvalid_o,
    input  logic              s_bready_i,
    input  logic [ADDR_W-1:0] s_araddr_i,
    input  logic              s_arvalid_i,
    output logic              s_arready_o,
    output logic [DATA_W-1:0] s_rdata_o,
    output logic [1:0]        s_rresp_o,
    output logic              s_rvalid_o,
    input  logic              s_rready_i,
    output logic [CH_W-1:0]   out_r_o,
    output logic [CH_W-1:0]   out_g_o,
    output logic [CH_W-1:0]   out_b_o,
    output logic              out_de_o,
    output logic              out_vs_o
);

    pixel_t cam1_pix, cam2_pix, fuse_pix;
    logic   cam1_valid, cam2_valid, fuse_valid;
    logic   cam1_vs, cam2_vs; // aligned with the pixels
    logic   fuse_ovf;
    logic   frame_start;
    mode_t  mode;

    byte_packer u_pack1 (
        .core_clk (core_clk), .rst_i (rst_i), .data_i (cam1_data_i),
        .href_i (cam1_href_i), .vsync_i (cam1_vsync_i),
        .pix_o (cam1_pix), .pix_valid_o (cam1_valid), .vsync_o (cam1_vs)
    );

    byte_packer u_pack2 (
        .core_clk (core_clk), .rst_i (rst_i), .data_i (cam2_data_i),
        .href_i (cam2_href_i), .vsync_i (cam2_vsync_i),
        .pix_o (cam2_pix), .pix_valid_o (cam2_valid), .vsync_o (cam2_vs)
    );

    pixel_fuse u_fuse (
        .core_clk (core_clk), .rst_i (rst_i), .frame_i (cam1_vs),
        .cam1_pix_i (cam1_pix), .cam1_valid_i (cam1_valid),
        .cam2_pix_i (cam2_pix), .cam2_valid_i (cam2_valid),
        .fuse_pix_o (fuse_pix), .fuse_valid_o (fuse_valid), .ovf_o (fuse_ovf)
    );

    stream_select u_select (
        .core_clk (core_clk), .rst_i (rst_i), .mode_i (mode),
        .cam1_pix_i (cam1_pix), .cam1_valid_i (cam1_valid), .cam1_vs_i (cam1_vs),
        .cam2_pix_i (cam2_pix), .cam2_valid_i (cam2_valid), .cam2_vs_i (cam2_vs),
        .fuse_pix_i (fuse_pix), .fuse_valid_i (fuse_valid),
        .out_r_o (out_r_o), .out_g_o (out_g_o), .out_b_o (out_b_o),
        .out_de_o (out_de_o), .out_vs_o (out_vs_o), .frame_start_o (frame_start)
    );

    ctrl_regs u_regs (
        .core_clk (core_clk), .rst_i (rst_i),
        .s_awaddr_i (s_awaddr_i), .s_awvalid_i (s_awvalid_i), .s_awready_o (s_awready_o),
        .s_wdata_i (s_wdata_i), .s_wvalid_i (s_wvalid_i), .s_wready_o (s_wready_o),
        .s_bresp_o (s_bresp_o), .s_bvalid_o (s_bvalid_o), .s_bready_i (s_bready_i),
        .s_araddr_i (s_araddr_i), .s_arvalid_i (s_arvalid_i), .s_arready_o (s_arready_o),
        .s_rdata_o (s_rdata_o), .s_rresp_o (s_rresp_o), .s_rvalid_o (s_rvalid_o),
        .s_rready_i (s_rready_i), .frame_start_i (frame_start), .ovf_i (fuse_ovf),
        .mode_o (mode)
    );

endmodule

// File: sim/video_mux_checker.sv
// video mux protocol assertions
module video_mux_checker (
    input logic core_clk,
    input logic rst_i,
    input logic awvalid_i,
    input logic wvalid_i,
    input logic awready_i,
    input logic bvalid_i,
    input logic bready_i,
    input logic rvalid_i,
    input logic rready_i,
    input logic out_de_i
);

    int fails = 0; // read by the testbench verdict

    bvalid_hold: assert property (@(posedge core_clk) disable iff (rst_i)
        bvalid_i && !bready_i |=> bvalid_i)
        else begin
            $error("bvalid dropped before bready was seen");
            fails++;
        end

    rvalid_hold: assert property (@(posedge core_clk) disable iff (rst_i)
        rvalid_i && !rready_i |=> rvalid_i)
        else begin
            $error("rvalid dropped before rready was seen");
            fails++;
        end

    de_low_in_reset: assert property (@(posedge core_clk)
        rst_i |=> !out_de_i)
        else begin
            $error("out_de_o high while in reset");
            fails++;
        end

    awready_needs_valids: assert property (@(posedge core_clk) disable iff (rst_i)
        $rose(awready_i) |-> awvalid_i && wvalid_i)
        else begin
            $error("awready rose without awvalid and wvalid");
            fails++;
        end

endmodule

bind video_mux_top video_mux_checker u_chk (
    .core_clk  (core_clk),
    .rst_i     (rst_i),
    .awvalid_i (s_awvalid_i),
    .wvalid_i  (s_wvalid_i),
    .awready_i (s_awready_o),
    .bvalid_i  (s_bvalid_o),
    .bready_i  (s_bready_i),
    .rvalid_i  (s_rvalid_o),
    .rready_i  (s_rready_i),
    .out_de_i  (out_de_o)
);

// File: sim/video_mux_monitor.sv
// video output monitor
module video_mux_monitor import video_pkg::*; (
    input logic            core_clk,
    input logic            rst_i,
    input logic [CH_W-1:0] out_r_i,
    input logic [CH_W-1:0] out_g_i,
    input logic [CH_W-1:0] out_b_i,
    input logic            out_de_i,
    input logic            out_vs_i
);

    logic [3*CH_W-1:0] exp_q [$]; // expected rgb888, output order
    int checked       = 0;
    int errors        = 0;
    int vs_run        = 0; // cycles of the current vsync pulse
    int last_vs_width = 0;

    function automatic void push_expect(input logic [3*CH_W-1:0] rgb);
        exp_q.push_back(rgb);
    endfunction

    task automatic compare_channel(input string name, input logic [CH_W-1:0] exp_v,
                                   input logic [CH_W-1:0] act_v);
        checked++;
        if (act_v !== exp_v) begin
            errors++;
            $display("[FAIL] %s expected %h got %h", name, exp_v, act_v);
        end
    endtask

    always @(posedge core_clk) begin : watch_outputs
        logic [3*CH_W-1:0] exp_v;
        if (rst_i) begin
            vs_run = 0;
        end else begin
            if (out_vs_i) begin
                vs_run++;
            end else if (vs_run != 0) begin
                last_vs_width = vs_run; // pulse just ended
                vs_run        = 0;
            end
            if (out_de_i && exp_q.size() == 0) begin
                errors++;
                $display("output pixel at %0t appeared with no pixel expected", $time);
            end else if (out_de_i) begin
                exp_v = exp_q.pop_front();
                compare_channel("out_r_o", exp_v[3*CH_W-1 -: CH_W], out_r_i);
                compare_channel("out_g_o", exp_v[2*CH_W-1 -: CH_W], out_g_i);
                compare_channel("out_b_o", exp_v[CH_W-1:0], out_b_i);
            end
        end
    end

endmodule

// File: sim/tb_video_mux.sv
// dual camera video mux testbench
module tb_video_mux import video_pkg::*, ctrl_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int STIM_CYCLES = 6 * 140 + 16 * 12 + 5; // frames, axi accesses, reset

    logic              core_clk;
    logic              rst_i;
    logic [BYTE_W-1:0] cam1_data, cam2_data;
    logic              cam1_href, cam2_href, cam1_vsync, cam2_vsync;
    logic [ADDR_W-1:0] s_awaddr, s_araddr;
    logic              s_awvalid, s_awready, s_wvalid, s_wready;
    logic [DATA_W-1:0] s_wdata, s_rdata;
    logic [1:0]        s_bresp, s_rresp;
    logic              s_bvalid, s_bready, s_arvalid, s_arready, s_rvalid, s_rready;
    logic [CH_W-1:0]   out_r, out_g, out_b;
    logic              out_de, out_vs;

    logic [PIX_W-1:0] raw_mem [2][32]; // byte pairs per camera, high byte on top
    int frames_sent = 0;
    int reg_checked = 0;
    int reg_errors  = 0;
    int err_mark    = 0;

    video_mux_top u_dut (
        .core_clk (core_clk), .rst_i (rst_i),
        .cam1_data_i (cam1_data), .cam1_href_i (cam1_href), .cam1_vsync_i (cam1_vsync),
        .cam2_data_i (cam2_data), .cam2_href_i (cam2_href), .cam2_vsync_i (cam2_vsync),
        .s_awaddr_i (s_awaddr), .s_awvalid_i (s_awvalid), .s_awready_o (s_awready),
        .s_wdata_i (s_wdata), .s_wvalid_i (s_wvalid), .s_wready_o (s_wready),
        .s_bresp_o (s_bresp), .s_bvalid_o (s_bvalid), .s_bready_i (s_bready),
        .s_araddr_i (s_araddr), .s_arvalid_i (s_arvalid), .s_arready_o (s_arready),
        .s_rdata_o (s_rdata), .s_rresp_o (s_rresp), .s_rvalid_o (s_rvalid),
        .s_rready_i (s_rready), .out_r_o (out_r), .out_g_o (out_g), .out_b_o (out_b),
        .out_de_o (out_de), .out_vs_o (out_vs)
    );

    video_mux_monitor u_mon (
        .core_clk (core_clk), .rst_i (rst_i), .out_r_i (out_r), .out_g_i (out_g),
        .out_b_i (out_b), .out_de_i (out_de), .out_vs_i (out_vs)
    );

    always #(CLK_PERIOD / 2) core_clk = ~core_clk;

    // expected rgb888 for pixel k of a frame in the given mode
    function automatic logic [23:0] expected_rgb(input logic [1:0] fmode,
            input logic [7:0] hi1, input logic [7:0] lo1,
            input logic [7:0] hi2, input logic [7:0] lo2);
        logic [15:0] raw1, raw2;
        int r1, g1, b1, r2, g2, b2;
        raw1 = {hi1, lo1};
        raw2 = {hi2, lo2};
        r1 = raw1[4:0];   // low 5 bits become red
        g1 = raw1[10:5];
        b1 = raw1[15:11]; // top 5 bits become blue
        r2 = raw2[4:0];
        g2 = raw2[10:5];
        b2 = raw2[15:11];
        if (fmode == MODE_FUSE) begin
            r1 = (r1 + r2) / 2; // floor average per channel
            g1 = (g1 + g2) / 2;
            b1 = (b1 + b2) / 2;
        end else if (fmode == MODE_CAM2) begin
            r1 = r2;
            g1 = g2;
            b1 = b2;
        end
        return {5'(r1), 3'b000, 6'(g1), 2'b00, 5'(b1), 3'b000}; // zero low bits
    endfunction

    // href and byte of a camera k cycles into its pixel phase, 8 pixels per 20 cycles
    function automatic logic [8:0] cam_beat(input int cam, input int k, input int n);
        int idx;
        idx = (k / 20) * 8 + (k % 20) / 2;
        if (k < 0 || k % 20 >= 16 || idx >= n) begin
            return 9'h000;
        end
        return {1'b1, (k % 2 == 0) ? raw_mem[cam][idx][15:8] : raw_mem[cam][idx][7:0]};
    endfunction

    function automatic int total_errors();
        return reg_errors + u_mon.errors + u_dut.u_chk.fails;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        reg_checked++;
        if (act_v !== exp_v) begin
            reg_errors++;
            $display("[FAIL] %s expected %h got %h", name, exp_v, act_v);
        end
    endtask

    task automatic wait_drain();
        int cyc;
        cyc = 0;
        while (u_mon.exp_q.size() != 0 && cyc < 200) begin
            @(posedge core_clk);
            cyc++;
        end
        if (u_mon.exp_q.size() != 0) begin
            reg_errors++;
            $display("%0d expected output pixels never appeared", u_mon.exp_q.size());
            u_mon.exp_q.delete();
        end
        repeat (4) @(posedge core_clk); // catch stray pixels
    endtask

    // one frame, camera 2 leads camera 1 by off pixels
    task automatic run_frame(input int n, input int off, input bit use1, input bit use2,
                             input logic [1:0] fmode);
        logic [8:0] b1, b2;
        int k, total;
        for (k = 0; k < 32; k++) begin
            raw_mem[0][k] = 16'($urandom);
            raw_mem[1][k] = 16'($urandom);
        end
        if ((fmode == MODE_CAM1 && use1) || (fmode == MODE_CAM2 && use2) ||
            (fmode == MODE_FUSE && use1 && use2)) begin
            for (k = 0; k < n; k++) begin
                u_mon.push_expect(expected_rgb(fmode, raw_mem[0][k][15:8], raw_mem[0][k][7:0],
                                               raw_mem[1][k][15:8], raw_mem[1][k][7:0]));
            end
        end
        for (k = 0; k < 6; k++) begin
            @(posedge core_clk);
            cam1_vsync <= (k < 2);
            cam2_vsync <= (k < 3); // longer pulse marks camera 2
        end
        frames_sent++;
        total = 2 * off + ((n + 7) / 8) * 20;
        for (k = 0; k < total; k++) begin
            @(posedge core_clk);
            b1 = use1 ? cam_beat(0, k - 2 * off, n) : 9'h000;
            b2 = use2 ? cam_beat(1, k, n) : 9'h000;
            cam1_href <= b1[8];
            cam1_data <= b1[8] ? b1[7:0] : 8'($urandom); // idle bytes are noise
            cam2_href <= b2[8];
            cam2_data <= b2[8] ? b2[7:0] : 8'($urandom);
        end
        @(posedge core_clk);
        cam1_href <= 1'b0;
        cam2_href <= 1'b0;
        wait_drain();
        check_value("out_vs_o width", (fmode == MODE_CAM2) ? 3 : 2, u_mon.last_vs_width);
    endtask

    task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             output logic [1:0] resp);
        @(posedge core_clk);
        s_awaddr  <= addr;
        s_awvalid <= 1'b1;
        s_wdata   <= data;
        s_wvalid  <= 1'b1;
        do begin
            @(posedge core_clk);
        end while (!s_awready);
        check_value("s_wready_o", 32'h1, 32'(s_wready)); // rises with awready
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        do begin
            @(posedge core_clk);
        end while (!s_bvalid);
        repeat ($urandom_range(3, 0)) @(posedge core_clk); // master stalls
        s_bready <= 1'b1;
        @(posedge core_clk);
        resp = s_bresp;
        s_bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                            output logic [1:0] resp);
        @(posedge core_clk);
        s_araddr  <= addr;
        s_arvalid <= 1'b1;
        do begin
            @(posedge core_clk);
        end while (!s_arready);
        s_arvalid <= 1'b0;
        do begin
            @(posedge core_clk);
        end while (!s_rvalid);
        repeat ($urandom_range(3, 0)) @(posedge core_clk);
        s_rready <= 1'b1;
        @(posedge core_clk);
        data = s_rdata;
        resp = s_rresp;
        s_rready <= 1'b0;
    endtask

    task automatic end_test(input int num, input string name);
        int errs;
        errs     = total_errors() - err_mark;
        err_mark = total_errors();
        $display("test %0d %s: %s, %0d errors", num, name, (errs == 0) ? "ok" : "failed", errs);
    endtask

    initial begin
        #(STIM_CYCLES * 4 * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", STIM_CYCLES * 4);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [1:0]        resp;
        logic [DATA_W-1:0] rdata;
        int                fails;
        void'($urandom(32'h3462_1311));
        core_clk   = 1'b0;
        rst_i      = 1'b1;
        cam1_data  = '0;
        cam2_data  = '0;
        cam1_href  = 1'b0;
        cam2_href  = 1'b0;
        cam1_vsync = 1'b0;
        cam2_vsync = 1'b0;
        s_awaddr   = '0;
        s_awvalid  = 1'b0;
        s_wdata    = '0;
        s_wvalid   = 1'b0;
        s_bready   = 1'b0;
        s_araddr   = '0;
        s_arvalid  = 1'b0;
        s_rready   = 1'b0;
        repeat (5) @(posedge core_clk);
        rst_i <= 1'b0;
        repeat (2) @(posedge core_clk);

        run_frame($urandom_range(31, 12), 0, 1'b1, 1'b0, MODE_CAM1); // reset mode
        end_test(1, "camera 1 mode");

        axi_write(REG_MODE, 32'(MODE_CAM2), resp);
        check_value("s_bresp_o", RESP_OKAY, resp);
        run_frame($urandom_range(31, 12), $urandom_range(15, 0), 1'b1, 1'b1, MODE_CAM2);
        end_test(2, "camera 2 mode");

        axi_write(REG_STATUS, 32'h0, resp); // camera 1 alone overflowed fifo 1
        axi_write(REG_MODE, 32'(MODE_FUSE), resp);
        check_value("s_bresp_o", RESP_OKAY, resp);
        run_frame($urandom_range(31, 12), $urandom_range(15, 0), 1'b1, 1'b1, MODE_FUSE);
        axi_read(REG_STATUS, rdata, resp);
        check_value("s_rdata_o[0]", 32'h0, 32'(rdata[STAT_OVF_BIT]));
        end_test(3, "fusion mode");

        run_frame(20, 0, 1'b0, 1'b1, MODE_FUSE); // 20 camera 2 pixels, none on camera 1
        axi_read(REG_STATUS, rdata, resp);
        check_value("s_rdata_o[0]", 32'h1, 32'(rdata[STAT_OVF_BIT]));
        axi_write(REG_STATUS, 32'h0, resp);
        check_value("s_bresp_o", RESP_OKAY, resp);
        axi_read(REG_STATUS, rdata, resp);
        check_value("s_rdata_o[0]", 32'h0, 32'(rdata[STAT_OVF_BIT]));
        end_test(4, "overflow");

        axi_write(REG_MODE, 32'd3, resp);
        check_value("s_bresp_o", RESP_SLVERR, resp);
        axi_read(REG_MODE, rdata, resp);
        check_value("s_rdata_o", 32'(MODE_FUSE), rdata);
        axi_read(4'hC, rdata, resp); // unmapped
        check_value("s_rresp_o", RESP_SLVERR, resp);
        check_value("s_rdata_o", 32'h0, rdata);
        axi_read(REG_STATUS, rdata, resp);
        check_value("s_rdata_o[15:8]", frames_sent % 256, rdata[STAT_FRAME_LSB +: 8]);
        end_test(5, "register errors and frame count");

        axi_write(REG_MODE, 32'(MODE_CAM1), resp);
        fork
            run_frame(31, $urandom_range(15, 0), 1'b1, 1'b1, MODE_CAM1); // full length frame
            begin
                repeat (30) @(posedge core_clk); // lands inside the pixel phase
                axi_write(REG_MODE, 32'(MODE_CAM2), resp);
            end
        join
        run_frame($urandom_range(31, 12), $urandom_range(15, 0), 1'b1, 1'b1, MODE_CAM2);
        end_test(6, "mode change mid-frame");

        fails = total_errors();
        $display("checks passed %0d, failed %0d",
                 reg_checked + u_mon.checked - reg_errors - u_mon.errors, fails);
        if (fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: video_mux.f
common/video_pkg.sv
common/ctrl_pkg.sv
capture/byte_packer.sv
fusion/pixel_fifo.sv
fusion/pixel_fuse.sv
logic/ctrl_regs.sv
logic/stream_select.sv
logic/video_mux_top.sv
sim/video_mux_checker.sv
sim/video_mux_monitor.sv
sim/tb_video_mux.sv
